//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - include
    files:
      - verilog/icache_pkg.sv
      - verilog/icache_lookup.sv
      - verilog/axi_line_refill.sv
      - verilog/icache_fetch_ctrl.sv
      - verilog/icache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/axi_mem_model.sv
      - verif/icache_tb.sv

//--- build.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_lookup.sv
verilog/axi_line_refill.sv
verilog/icache_fetch_ctrl.sv
verilog/icache_top.sv
verif/axi_mem_model.sv
verif/icache_tb.sv

//--- include/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch and axi address width
`define ICACHE_ADDR_W 32

// one risc-v instruction
`define ICACHE_INSTR_W 32

// axi read beat width
`define ICACHE_AXI_DATA_W 64

// direct mapped geometry, 16 lines of 32 bytes
`define ICACHE_LINES 16
`define ICACHE_INDEX_W 4
`define ICACHE_BEATS 4
`define ICACHE_OFFSET_W 5
`define ICACHE_TAG_W 23

// axi id width, only id 0 is ever issued
`define ICACHE_AXI_ID_W 4

// axi encodings
`define AXI_BURST_INCR 2'b01
`define AXI_RESP_OKAY 2'b00
`define AXI_ARCACHE_NORMAL_NC 4'b0010
// unprivileged, secure, instruction access
`define AXI_PROT_INSTR 3'b100

// 8 bytes per beat
`define ICACHE_AR_SIZE 3'd3

`endif

//--- verif/axi_mem_model.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module axi_mem_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                ar_valid_i,
    input  icache_pkg::axi_ar_t ar_i,
    output logic                ar_ready_o,
    output logic                r_valid_o,
    output icache_pkg::axi_r_t  r_o,
    input  logic                r_ready_i
);
    import icache_pkg::*;

    // lcg state for ready/valid gaps
    logic [31:0] rng_q;

    // burst being served
    logic                      rd_active;
    logic [`ICACHE_ADDR_W-1:0] base_q;
    logic [`ICACHE_ADDR_W-1:0] beat_addr;
    logic [7:0]                beat_q;
    logic [7:0]                len_q;
    logic [1:0]                ar_wait;
    logic [1:0]                r_wait;
    logic [1:0]                gap;

    // 0 to 3 cycles
    function automatic logic [1:0] next_delay();
        rng_q = rng_q * 32'd1664525 + 32'd1013904223;
        return rng_q[17:16];
    endfunction

    // memory contents, word address xor a fixed pattern
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    // incr burst, 8 bytes per beat
    assign beat_addr = base_q + {beat_q, 3'b000};
    assign r_o.data  = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
    // bit 30 marks the slverr region
    assign r_o.resp  = base_q[30] ? 2'b10 : 2'b00;
    assign r_o.last  = beat_q == len_q;
    assign r_o.id    = '0;

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            rng_q      = 32'h49d25f19;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            rd_active  <= 1'b0;
            base_q     <= '0;
            beat_q     <= '0;
            len_q      <= '0;
            r_wait     <= '0;
            ar_wait    <= next_delay();
        end else if (ar_valid_i && ar_ready_o) begin
            // address accepted, data after a random gap
            ar_ready_o <= 1'b0;
            rd_active  <= 1'b1;
            base_q     <= ar_i.addr;
            len_q      <= ar_i.len;
            beat_q     <= '0;
            r_wait     <= next_delay();
        end else if (rd_active) begin
            if (r_valid_o && r_ready_i) begin
                gap = next_delay();
                beat_q <= beat_q + 8'd1;
                if (r_o.last) begin
                    rd_active <= 1'b0;
                    r_valid_o <= 1'b0;
                    ar_wait   <= gap;
                end else begin
                    // zero gap keeps valid up for the next beat
                    r_valid_o <= gap == 2'd0;
                    r_wait    <= gap - 2'd1;
                end
            end else if (!r_valid_o) begin
                if (r_wait == 2'd0) begin
                    r_valid_o <= 1'b1;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end else if (ar_valid_i) begin
            if (ar_wait == 2'd0) begin
                ar_ready_o <= 1'b1;
            end else begin
                ar_wait <= ar_wait - 2'd1;
            end
        end
    end

endmodule

//--- verif/icache_tb.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int STREAM_LEN      = 8;
    localparam int RANDOM_FETCHES  = 8;
    localparam int CONFLICT_ROUNDS = 3;
    // every fetch issued by the sequence below
    localparam int FETCH_COUNT = 2 + STREAM_LEN + RANDOM_FETCHES + 2 * CONFLICT_ROUNDS + 8;
    // worst case miss in cycles
    localparam int MISS_CYCLES = 20;
    // len 3, size 3, incr, id 0, normal non-cacheable, unprivileged secure instruction
    localparam logic [23:0] AR_FMT_EXP = {8'd3, 3'd3, 2'b01, 4'd0, 4'b0010, 3'b100};

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       fetch_req;
    fetch_addr_t                fetch_addr;
    logic                       flush;
    logic                       fetch_valid;
    logic [`ICACHE_INSTR_W-1:0] fetch_instr;
    logic                       fetch_err;
    logic                       busy;
    logic                       ar_valid;
    axi_ar_t                    ar;
    logic                       ar_ready;
    logic                       r_valid;
    axi_r_t                     r;
    logic                       r_ready;

    // reference model of the tag store
    logic                       ref_valid [`ICACHE_LINES];
    logic [`ICACHE_TAG_W-1:0]   ref_tag [`ICACHE_LINES];
    int unsigned                ar_count;
    int unsigned                accept_count;
    int unsigned                done_count;

    // the fetch in flight
    logic                       pending_q;
    fetch_addr_t                exp_addr_q;
    logic                       exp_hit_q;
    int unsigned                ar_base_q;

    // ar waiting for ready in the last cycle
    logic                       ar_stall_q;
    axi_ar_t                    ar_prev_q;

    logic [31:0]                rng_q;
    logic                       accept;
    logic                       flush_take;
    logic                       line_hit;
    logic [31:0]                exp_word_addr;
    logic [31:0]                exp_instr;
    logic [31:0]                exp_line_addr;
    logic [31:0]                ar_seen;
    logic [31:0]                ar_exp;
    logic [23:0]                ar_fmt;

    always #(CLK_PERIOD / 2) clk = ~clk;

    icache_top icache_top_inst (
        .clk           (clk),
        .reset         (reset),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .flush_i       (flush),
        .fetch_valid_o (fetch_valid),
        .fetch_instr_o (fetch_instr),
        .fetch_err_o   (fetch_err),
        .busy_o        (busy),
        .ar_valid_o    (ar_valid),
        .ar_o          (ar),
        .ar_ready_i    (ar_ready),
        .r_valid_i     (r_valid),
        .r_i           (r),
        .r_ready_o     (r_ready)
    );

    axi_mem_model axi_mem_model_inst (
        .clk        (clk),
        .reset      (reset),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

    function automatic logic [31:0] next_rand();
        rng_q = rng_q * 32'd1664525 + 32'd1013904223;
        return rng_q;
    endfunction

    // expected word at a fetch address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    assign accept        = fetch_req && !busy;
    assign flush_take    = flush && !busy;
    assign exp_word_addr = exp_addr_q;
    assign exp_instr     = mem_word(exp_word_addr);
    assign exp_line_addr = {exp_word_addr[31:5], 5'b0};
    assign ar_seen       = ar_count - ar_base_q;
    assign ar_exp        = exp_hit_q ? 32'd0 : 32'd1;
    assign ar_fmt        = {ar.len, ar.size, ar.burst, ar.id, ar.cache, ar.prot};

    // would the request now on the port hit
    always_comb begin
        line_hit = ref_valid[fetch_addr.index] && ref_tag[fetch_addr.index] == fetch_addr.tag;
        // a line completing this cycle already counts
        if (fetch_valid && pending_q && exp_addr_q.index == fetch_addr.index) begin
            line_hit = !exp_word_addr[30] && exp_addr_q.tag == fetch_addr.tag;
        end
        // same cycle flush is seen by the request
        if (flush_take) begin
            line_hit = 1'b0;
        end
    end

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                ref_valid[i] <= 1'b0;
                ref_tag[i]   <= '0;
            end
            ar_count     <= 0;
            accept_count <= 0;
            done_count   <= 0;
            pending_q    <= 1'b0;
            exp_addr_q   <= '0;
            exp_hit_q    <= 1'b0;
            ar_base_q    <= 0;
            ar_stall_q   <= 1'b0;
            ar_prev_q    <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_count <= ar_count + 1;
            end
            ar_stall_q <= ar_valid && !ar_ready;
            ar_prev_q  <= ar;
            // lines in the slverr region stay invalid
            if (fetch_valid && pending_q) begin
                ref_valid[exp_addr_q.index] <= !exp_word_addr[30];
                ref_tag[exp_addr_q.index]   <= exp_addr_q.tag;
                done_count                  <= done_count + 1;
            end
            if (flush_take) begin
                for (int i = 0; i < `ICACHE_LINES; i++) begin
                    ref_valid[i] <= 1'b0;
                end
            end
            if (accept) begin
                pending_q    <= 1'b1;
                exp_addr_q   <= fetch_addr;
                exp_hit_q    <= line_hit;
                ar_base_q    <= ar_count;
                accept_count <= accept_count + 1;
            end else if (fetch_valid) begin
                pending_q <= 1'b0;
            end
        end
    end

    // outputs quiet in reset
    assert property (@(posedge clk) !reset |-> !fetch_valid && !fetch_err && !busy
                     && !ar_valid && !r_ready)
        else report_problem("outputs not low during reset");

    // data and error of each result
    assert property (@(posedge clk) disable iff (!reset)
                     fetch_valid && !fetch_err |-> fetch_instr == exp_instr)
        else value_mismatch("fetch_instr_o", $sampled(exp_instr), $sampled(fetch_instr));
    assert property (@(posedge clk) disable iff (!reset)
                     fetch_valid && fetch_err |-> fetch_instr == '0)
        else value_mismatch("fetch_instr_o", 32'd0, $sampled(fetch_instr));
    assert property (@(posedge clk) disable iff (!reset)
                     fetch_valid |-> fetch_err == exp_word_addr[30])
        else value_mismatch("fetch_err_o", $sampled(exp_word_addr[30]), $sampled(fetch_err));
    assert property (@(posedge clk) disable iff (!reset) fetch_valid |-> pending_q)
        else report_problem("fetch_valid_o with no fetch outstanding");

    // hit one cycle after acceptance
    assert property (@(posedge clk) disable iff (!reset) pending_q && exp_hit_q |-> fetch_valid)
        else report_problem("hit did not complete in the cycle after acceptance");

    // one ar per miss, none per hit
    assert property (@(posedge clk) disable iff (!reset) fetch_valid |-> ar_seen == ar_exp)
        else value_mismatch("ar handshakes", $sampled(ar_exp), $sampled(ar_seen));

    // busy tracks the outstanding miss exactly
    assert property (@(posedge clk) disable iff (!reset) busy |-> pending_q && !exp_hit_q)
        else report_problem("busy_o high with no miss outstanding");
    assert property (@(posedge clk) disable iff (!reset)
                     pending_q && !exp_hit_q && !fetch_valid |-> busy)
        else report_problem("busy_o low while a miss is outstanding");

    // ar payload and stability
    assert property (@(posedge clk) disable iff (!reset) ar_valid |-> ar.addr == exp_line_addr)
        else value_mismatch("ar_o.addr", $sampled(exp_line_addr), $sampled(ar.addr));
    assert property (@(posedge clk) disable iff (!reset) ar_valid |-> ar_fmt == AR_FMT_EXP)
        else value_mismatch("ar_o.len/size/burst/id/cache/prot", AR_FMT_EXP, $sampled(ar_fmt));
    assert property (@(posedge clk) disable iff (!reset) ar_stall_q |-> ar_valid && ar == ar_prev_q)
        else report_problem("ar_valid_o or ar_o changed before ar_ready_i");
    assert property (@(posedge clk) disable iff (!reset) r_valid |-> r_ready)
        else report_problem("r_ready_o low while a data beat was presented");

    // issue one fetch and wait for its result
    task automatic fetch_one(input logic [31:0] addr, input logic with_flush);
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        flush      <= with_flush;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        fetch_req <= 1'b0;
        flush     <= 1'b0;
        do begin
            @(posedge clk);
        end while (!fetch_valid);
    endtask

    // a request every cycle through consecutive words
    task automatic fetch_stream(input logic [31:0] base, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            fetch_req  <= 1'b1;
            fetch_addr <= base + 32'(4 * i);
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (!fetch_valid);
    endtask

    task automatic flush_lines();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // watchdog
    initial begin
        #((RESET_CYCLES + FETCH_COUNT * MISS_CYCLES) * CLK_PERIOD);
        report_problem("timeout: fetch never completed");
    end

    initial begin
        rng_q      = 32'h49d25f19;
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        flush      = 1'b0;
        #1;
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        // cold miss, then hits in the same line
        fetch_one(32'h0000_1000, 1'b0);
        fetch_one(32'h0000_1004, 1'b0);
        fetch_stream(32'h0000_1000, STREAM_LEN);
        // scattered misses below the error region
        repeat (RANDOM_FETCHES) fetch_one(next_rand() & 32'h3fff_fffc, 1'b0);
        // two tags on index 2
        repeat (CONFLICT_ROUNDS) begin
            fetch_one(32'h0000_2040, 1'b0);
            fetch_one(32'h0010_2044, 1'b0);
        end
        // slverr line, refetch, then a good line on the same index
        fetch_one(32'h4000_0300, 1'b0);
        fetch_one(32'h4000_0308, 1'b0);
        fetch_one(32'h0000_0300, 1'b0);
        // flush alone, then flush with a request
        fetch_one(32'h0000_3000, 1'b0);
        fetch_one(32'h0000_3004, 1'b0);
        flush_lines();
        fetch_one(32'h0000_3008, 1'b0);
        fetch_one(32'h0000_300c, 1'b0);
        fetch_one(32'h0000_3010, 1'b1);
        while (pending_q) begin
            @(posedge clk);
        end
        if (done_count == accept_count && accept_count != 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_problem("not every accepted fetch returned a result");
        end
    end

endmodule

//--- verilog/axi_line_refill.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module axi_line_refill (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_i,
    input  icache_pkg::fetch_addr_t    line_addr_i,
    input  logic                       ar_ready_i,
    input  logic                       r_valid_i,
    input  icache_pkg::axi_r_t         r_i,
    output logic                       ar_valid_o,
    output icache_pkg::axi_ar_t        ar_o,
    output logic                       r_ready_o,
    output logic                       fill_we_o,
    output icache_pkg::refill_beat_t   fill_beat_o,
    output logic                       done_o,
    output icache_pkg::refill_result_t result_o
);
    import icache_pkg::*;

    // idle, address phase, data phase
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_AR,
        RF_R
    } rf_state_t;

    rf_state_t state_q;

    // line being filled
    logic [`ICACHE_TAG_W-1:0]   tag_q;
    logic [`ICACHE_INDEX_W-1:0] index_q;

    // beat counter and sticky error
    logic [$clog2(`ICACHE_BEATS)-1:0] beat_q;
    logic                             err_q;

    logic beat_fire;
    logic beat_err;
    logic line_err;

    // r_ready is held for the whole data phase
    assign beat_fire = (state_q == RF_R) && r_valid_i;
    assign beat_err  = r_i.resp != `AXI_RESP_OKAY;
    // slverr or decerr on any beat fails the line
    assign line_err  = err_q || beat_err;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= RF_IDLE;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (start_i) begin
                        state_q <= RF_AR;
                    end
                end
                RF_AR: begin
                    if (ar_ready_i) begin
                        state_q <= RF_R;
                    end
                end
                RF_R: begin
                    // last closes the burst
                    if (beat_fire && r_i.last) begin
                        state_q <= RF_IDLE;
                    end
                end
                default: begin
                    state_q <= RF_IDLE;
                end
            endcase
        end
    end

    // counter and error restart with every line
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (state_q == RF_IDLE && start_i) begin
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
            err_q  <= line_err;
        end
    end

    // line identity, held stable through ar and r
    always_ff @(posedge clk) begin
        if (state_q == RF_IDLE && start_i) begin
            tag_q   <= line_addr_i.tag;
            index_q <= line_addr_i.index;
        end
    end

    // ar payload straight from registers, stable until ready
    assign ar_valid_o = state_q == RF_AR;
    assign ar_o.addr  = {tag_q, index_q, {`ICACHE_OFFSET_W{1'b0}}};
    assign ar_o.id    = '0;
    assign ar_o.len   = 8'(`ICACHE_BEATS - 1);
    assign ar_o.size  = `ICACHE_AR_SIZE;
    assign ar_o.burst = `AXI_BURST_INCR;
    assign ar_o.cache = `AXI_ARCACHE_NORMAL_NC;
    assign ar_o.prot  = `AXI_PROT_INSTR;

    assign r_ready_o = state_q == RF_R;

    // every accepted beat is written, even an errored one
    assign fill_we_o         = beat_fire;
    assign fill_beat_o.index = index_q;
    assign fill_beat_o.beat  = beat_q;
    assign fill_beat_o.data  = r_i.data;

    // done in the cycle of the last beat
    assign done_o          = beat_fire && r_i.last;
    assign result_o.index  = index_q;
    assign result_o.tag    = tag_q;
    assign result_o.ok     = !line_err;
    assign result_o.err    = line_err;

endmodule

//--- verilog/icache_fetch_ctrl.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_fetch_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetch_req_i,
    input  icache_pkg::fetch_addr_t    fetch_addr_i,
    input  logic                       hit_i,
    input  logic [`ICACHE_INSTR_W-1:0] instr_i,
    input  logic                       done_i,
    input  icache_pkg::refill_result_t result_i,
    output logic                       lookup_req_o,
    output icache_pkg::fetch_addr_t    lookup_addr_o,
    output logic                       refill_start_o,
    output logic                       fetch_valid_o,
    output logic [`ICACHE_INSTR_W-1:0] fetch_instr_o,
    output logic                       fetch_err_o,
    output logic                       busy_o
);
    import icache_pkg::*;

    // idle, waiting for the refill, replaying, reporting an error
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_REPLAY,
        ST_REPORT
    } state_t;

    state_t state_q;

    // the single outstanding lookup
    logic        pend_q;
    fetch_addr_t addr_q;

    logic hit;
    logic miss;

    // a lookup is only pending out of idle or replay, so state is idle here
    assign hit  = pend_q && hit_i;
    assign miss = pend_q && !hit_i;

    // busy already in the miss cycle, so no new request slips in
    assign busy_o = miss || (state_q == ST_FILL) || (state_q == ST_REPLAY);

    // new fetch when free, or the replay of the missed one
    assign lookup_req_o  = (fetch_req_i && !busy_o) || (state_q == ST_REPLAY);
    // while busy the held address also feeds the refill master
    assign lookup_addr_o = busy_o ? addr_q : fetch_addr_i;

    assign refill_start_o = miss;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (miss) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    // error goes straight to the report, no replay
                    if (done_i) begin
                        state_q <= result_i.err ? ST_REPORT : ST_REPLAY;
                    end
                end
                ST_REPLAY: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= lookup_req_o;
        end
    end

    // address of the lookup in flight
    always_ff @(posedge clk) begin
        if (lookup_req_o) begin
            addr_q <= lookup_addr_o;
        end
    end

    // result pulses, hit data or the error with a zero word
    assign fetch_valid_o = hit || (state_q == ST_REPORT);
    assign fetch_err_o   = state_q == ST_REPORT;
    assign fetch_instr_o = hit ? instr_i : '0;

endmodule

//--- verilog/icache_lookup.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_lookup (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           lookup_req_i,
    input  icache_pkg::fetch_addr_t        lookup_addr_i,
    input  logic                           flush_i,
    input  logic                           fill_we_i,
    input  icache_pkg::refill_beat_t       fill_beat_i,
    input  logic                           fill_done_i,
    input  icache_pkg::refill_result_t     fill_result_i,
    output logic                           hit_o,
    output logic [`ICACHE_INSTR_W-1:0]     instr_o
);
    import icache_pkg::*;

    // one valid bit per line
    logic [`ICACHE_LINES-1:0] valid_q;

    // tag per line
    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_LINES];

    // data array addressed by {index, beat}
    logic [`ICACHE_AXI_DATA_W-1:0] data_mem [`ICACHE_LINES*`ICACHE_BEATS];

    // registered lookup
    logic                          req_q;
    fetch_addr_t                   addr_q;
    logic [`ICACHE_AXI_DATA_W-1:0] beat_q;

    // beat holding the requested word
    logic [`ICACHE_INDEX_W+$clog2(`ICACHE_BEATS)-1:0] rd_sel;
    logic [`ICACHE_INDEX_W+$clog2(`ICACHE_BEATS)-1:0] wr_sel;

    assign rd_sel = {lookup_addr_i.index, lookup_addr_i.word[`ICACHE_OFFSET_W-3:1]};
    assign wr_sel = {fill_beat_i.index, fill_beat_i.beat};

    // lookup in flight, cleared on reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req_q <= 1'b0;
        end else begin
            req_q <= lookup_req_i;
        end
    end

    // address and beat are sampled at the request edge
    always_ff @(posedge clk) begin
        if (lookup_req_i) begin
            addr_q <= lookup_addr_i;
            beat_q <= data_mem[rd_sel];
        end
    end

    // refill beats land here
    // no lookup is issued while a refill runs
    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            data_mem[wr_sel] <= fill_beat_i.data;
        end
    end

    // tag written at the end of every refill
    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_mem[fill_result_i.index] <= fill_result_i.tag;
        end
    end

    // valid bits
    // flush wins, a failed refill leaves the line invalid
    // since its data beats were overwritten
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_done_i) begin
            valid_q[fill_result_i.index] <= fill_result_i.ok;
        end
    end

    // tag compare against the registered address
    // sees a flush or fill from the request edge
    assign hit_o = req_q
                && valid_q[addr_q.index]
                && (tag_mem[addr_q.index] == addr_q.tag);

    // lower word sits in the low half of the beat
    assign instr_o = addr_q.word[0] ? beat_q[`ICACHE_INSTR_W +: `ICACHE_INSTR_W]
                                    : beat_q[0 +: `ICACHE_INSTR_W];

endmodule

//--- verilog/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // fetch address as the cache sees it
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]      tag;
        logic [`ICACHE_INDEX_W-1:0]    index;
        // 32-bit word within the line
        logic [`ICACHE_OFFSET_W-3:0]   word;
        logic [1:0]                    byte_sel;
    } fetch_addr_t;

    // read address channel payload
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0]     addr;
        logic [`ICACHE_AXI_ID_W-1:0]   id;
        logic [7:0]                    len;
        logic [2:0]                    size;
        logic [1:0]                    burst;
        logic [3:0]                    cache;
        logic [2:0]                    prot;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [`ICACHE_AXI_DATA_W-1:0] data;
        logic [1:0]                    resp;
        logic                          last;
        logic [`ICACHE_AXI_ID_W-1:0]   id;
    } axi_r_t;

    // one beat written into the data array
    typedef struct packed {
        logic [`ICACHE_INDEX_W-1:0]       index;
        logic [$clog2(`ICACHE_BEATS)-1:0] beat;
        logic [`ICACHE_AXI_DATA_W-1:0]    data;
    } refill_beat_t;

    // end of refill, line identity and outcome
    typedef struct packed {
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       ok;
        logic                       err;
    } refill_result_t;

endpackage

//--- verilog/icache_top.sv
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       reset,
    // fetch side
    input  logic                       fetch_req_i,
    input  icache_pkg::fetch_addr_t    fetch_addr_i,
    input  logic                       flush_i,
    output logic                       fetch_valid_o,
    output logic [`ICACHE_INSTR_W-1:0] fetch_instr_o,
    output logic                       fetch_err_o,
    output logic                       busy_o,
    // axi read channels
    output logic                       ar_valid_o,
    output icache_pkg::axi_ar_t        ar_o,
    input  logic                       ar_ready_i,
    input  logic                       r_valid_i,
    input  icache_pkg::axi_r_t         r_i,
    output logic                       r_ready_o
);
    import icache_pkg::*;

    logic                       lookup_req;
    fetch_addr_t                lookup_addr;
    logic                       hit;
    logic [`ICACHE_INSTR_W-1:0] instr;
    logic                       refill_start;
    logic                       fill_we;
    refill_beat_t               fill_beat;
    logic                       refill_done;
    refill_result_t             refill_result;
    logic                       flush_idle;

    // flush only acts while no miss is outstanding
    assign flush_idle = flush_i && !busy_o;

    icache_fetch_ctrl icache_fetch_ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .hit_i          (hit),
        .instr_i        (instr),
        .done_i         (refill_done),
        .result_i       (refill_result),
        .lookup_req_o   (lookup_req),
        .lookup_addr_o  (lookup_addr),
        .refill_start_o (refill_start),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_err_o    (fetch_err_o),
        .busy_o         (busy_o)
    );

    icache_lookup icache_lookup_inst (
        .clk           (clk),
        .reset         (reset),
        .lookup_req_i  (lookup_req),
        .lookup_addr_i (lookup_addr),
        .flush_i       (flush_idle),
        .fill_we_i     (fill_we),
        .fill_beat_i   (fill_beat),
        .fill_done_i   (refill_done),
        .fill_result_i (refill_result),
        .hit_o         (hit),
        .instr_o       (instr)
    );

    // line address is the held miss address from the controller
    axi_line_refill axi_line_refill_inst (
        .clk         (clk),
        .reset       (reset),
        .start_i     (refill_start),
        .line_addr_i (lookup_addr),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_i         (r_i),
        .ar_valid_o  (ar_valid_o),
        .ar_o        (ar_o),
        .r_ready_o   (r_ready_o),
        .fill_we_o   (fill_we),
        .fill_beat_o (fill_beat),
        .done_o      (refill_done),
        .result_o    (refill_result)
    );

endmodule
